// ==== design/mmt_pkg.sv ====
package mmt_pkg;

    // ==================================================================
    // Sizes
    // ==================================================================
    localparam int MAX_DIM   = 16;
    localparam int ELEM_W    = 8;
    localparam int TMP_W     = 20;
    localparam int ACC_W     = 36;
    localparam int OUT_W     = 50;
    localparam int IDX_W     = 5;
    // One temporary element per entry of a full-size T matrix
    localparam int TMP_DEPTH = MAX_DIM * MAX_DIM;

    // ==================================================================
    // Data types
    // ==================================================================
    typedef logic signed [ELEM_W-1:0] elem_t;
    // Lane 0 sits in the low byte
    typedef elem_t [MAX_DIM-1:0] row_t;
    typedef logic signed [TMP_W-1:0] tmp_t;
    typedef logic signed [ACC_W-1:0] acc_t;

    typedef enum logic [2:0] {IDLE, LOAD, QUERY, PRODUCT, TRACE, DONE} mmt_state_e;

    // Size code to dimension minus one
    function automatic logic [3:0] dim_of(input logic [1:0] code);
        case (code)
            2'd0:    return 4'd1;
            2'd1:    return 4'd3;
            2'd2:    return 4'd7;
            default: return 4'd15;
        endcase
    endfunction

    // Size code to log2 of the dimension, for row addressing
    function automatic logic [2:0] shift_of(input logic [1:0] code);
        case (code)
            2'd0:    return 3'd1;
            2'd1:    return 3'd2;
            2'd2:    return 3'd3;
            default: return 3'd4;
        endcase
    endfunction

endpackage

// ==== design/mmt_ifs.sv ====
// Read port of the weight memory
interface mem_rd_if #(
    parameter type word_t = logic,
    parameter int  DEPTH  = 16
);
    logic                     rd_en;
    logic [$clog2(DEPTH)-1:0] addr;
    word_t                    rdata;
    // High while the store owns the memory
    logic                     busy;

    modport master (output rd_en, output addr, input rdata, input busy);
    modport slave  (input rd_en, input addr, output rdata, output busy);
endinterface

// Commands to the multiply-accumulate unit
interface mac_cmd_if;
    import mmt_pkg::*;

    logic load_a;
    logic load_b;
    logic shift_t;
    logic acc_clear;
    logic acc_en;
    logic trace_sel;
    // Lane sum, plus acc when acc_en is set
    acc_t dot;
    acc_t acc;

    modport master (
        output load_a, output load_b, output shift_t,
        output acc_clear, output acc_en, output trace_sel,
        input  dot, input acc
    );
    modport slave (
        input  load_a, input load_b, input shift_t,
        input  acc_clear, input acc_en, input trace_sel,
        output dot, output acc
    );
endinterface

// ==== design/row_sram.sv ====
// Single-port synchronous memory with registered read data
module row_sram #(
    parameter type word_t = logic,
    parameter int  DEPTH  = 16
) (
    input  logic                     clk,
    input  logic                     we,
    input  logic [$clog2(DEPTH)-1:0] addr,
    input  word_t                    wdata,
    output word_t                    rdata
);

    word_t mem [DEPTH];

    // Read returns the old word on a same-address write
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
        rdata <= mem[addr];
    end

endmodule

// ==== design/matrix_store.sv ====
module matrix_store #(
    parameter int NUM_MATS = 32
) (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           in_valid,
    input  mmt_pkg::elem_t matrix,
    input  logic [1:0]     matrix_size,
    mem_rd_if.slave        rd
);
    import mmt_pkg::*;

    localparam int W_DEPTH = NUM_MATS * MAX_DIM;
    localparam int W_AW    = $clog2(W_DEPTH);

    logic            in_valid_d;
    logic            start;
    logic [3:0]      dim_q;
    logic [3:0]      cur_dim;
    logic [3:0]      col_cnt;
    logic            row_done;
    logic            we_q;
    row_t            row_buf;
    row_t            shifted;
    logic [W_AW-1:0] wr_addr;
    logic [W_AW-1:0] rd_addr_q;
    logic [W_AW-1:0] mem_addr;

    // Size is taken from the first byte cycle
    assign start    = in_valid && !in_valid_d;
    assign cur_dim  = start ? dim_of(matrix_size) : dim_q;
    assign row_done = in_valid && (col_cnt == cur_dim);
    assign shifted  = row_t'(row_buf >> ELEM_W);

    // Writes win the port, otherwise hold the last read address
    assign mem_addr = we_q ? wr_addr : (rd.rd_en ? rd.addr : rd_addr_q);
    assign rd.busy  = in_valid || we_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            in_valid_d <= 1'b0;
            dim_q      <= '0;
            col_cnt    <= '0;
            we_q       <= 1'b0;
            wr_addr    <= '0;
            rd_addr_q  <= '0;
        end else begin
            in_valid_d <= in_valid;
            dim_q      <= cur_dim;
            we_q       <= row_done;
            if (!in_valid || row_done) begin
                col_cnt <= '0;
            end else begin
                col_cnt <= col_cnt + 4'd1;
            end
            if (we_q) begin
                wr_addr <= wr_addr + 1'b1;
            end
            if (start) begin
                wr_addr <= '0;
            end
            if (rd.rd_en) begin
                rd_addr_q <= rd.addr;
            end
        end
    end

    // New byte enters at the top used lane, older ones move down
    always_ff @(posedge clk) begin
        if (in_valid) begin
            for (int l = 0; l < MAX_DIM; l++) begin
                if (l == cur_dim) begin
                    row_buf[l] <= matrix;
                end else if (l < cur_dim) begin
                    row_buf[l] <= shifted[l];
                end else begin
                    row_buf[l] <= '0;
                end
            end
        end
    end

    row_sram #(.word_t(row_t), .DEPTH(W_DEPTH)) u_wmem (
        .clk   (clk),
        .we    (we_q),
        .addr  (mem_addr),
        .wdata (row_buf),
        .rdata (rd.rdata)
    );

endmodule

// ==== design/mmt_ctrl.sv ====
module mmt_ctrl #(
    parameter int NUM_MATS = 32
) (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  in_valid,
    input  logic                                  in_valid2,
    input  logic [1:0]                            matrix_size,
    input  logic [mmt_pkg::IDX_W-1:0]             matrix_idx,
    mem_rd_if.master                              rd,
    mac_cmd_if.master                             mac,
    output logic                                  t_we,
    output logic [$clog2(mmt_pkg::TMP_DEPTH)-1:0] t_addr,
    output mmt_pkg::tmp_t                         t_wdata,
    output logic                                  out_valid,
    output logic signed [mmt_pkg::OUT_W-1:0]      out_value
);
    import mmt_pkg::*;

    localparam int W_AW = $clog2(NUM_MATS * MAX_DIM);
    localparam int T_AW = $clog2(TMP_DEPTH);

    mmt_state_e            state, state_nxt;
    logic [3:0]            dim_m1, row_i;
    logic [2:0]            shft;
    logic [2:0][IDX_W-1:0] idx_q;
    logic [4:0]            cnt, cnt_lim, c1, c2;
    logic                  prod, drain, v0, v1, v2, last0, l1, l2;
    logic [T_AW-1:0]       wr_ptr;

    // ==================================================================
    // Issue stage. PRODUCT walks A row then all B rows, TRACE walks T
    // ==================================================================
    assign prod    = (state == PRODUCT);
    assign cnt_lim = prod ? {1'b0, dim_m1} + 5'd1 : {1'b0, dim_m1};
    assign v0      = (prod || state == TRACE) && !drain && !rd.busy;
    assign last0   = v0 && (row_i == dim_m1) && (cnt == cnt_lim);

    always_comb begin
        rd.rd_en = v0 && (prod || cnt == cnt_lim);
        if (prod && cnt != '0) begin
            rd.addr = (W_AW'(idx_q[1]) << shft) + W_AW'(cnt - 5'd1);
        end else if (prod) begin
            rd.addr = (W_AW'(idx_q[0]) << shft) + W_AW'(row_i);
        end else begin
            rd.addr = (W_AW'(idx_q[2]) << shft) + W_AW'(row_i);
        end
    end

    // T row read backwards so element 0 ends up in lane 0
    assign t_addr  = prod ? wr_ptr : (T_AW'(row_i) << shft) + T_AW'(dim_m1 - cnt[3:0]);
    assign t_we    = prod && v2 && (c2 != '0);
    assign t_wdata = tmp_t'(mac.dot);

    // Stage 1 loads operands, stage 2 consumes the dot
    assign mac.load_a    = prod && v1 && (c1 == '0);
    assign mac.load_b    = v1 && (prod ? (c1 != '0) : (c1 == cnt_lim));
    assign mac.shift_t   = !prod && v1;
    assign mac.trace_sel = (state == TRACE);
    assign mac.acc_en    = !prod && v2 && (c2 == cnt_lim);
    assign mac.acc_clear = (state == QUERY);

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE:    if (in_valid) state_nxt = LOAD;
                     else if (in_valid2) state_nxt = QUERY;
            LOAD:    if (!in_valid) state_nxt = IDLE;
            QUERY:   if (!in_valid2) state_nxt = PRODUCT;
            PRODUCT: if (l2) state_nxt = TRACE;
            TRACE:   if (l2) state_nxt = DONE;
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= IDLE;
            dim_m1    <= '0;
            shft      <= '0;
            idx_q     <= '0;
            {cnt, c1, c2, row_i, wr_ptr} <= '0;
            {drain, v1, v2, l1, l2} <= '0;
            out_valid <= 1'b0;
            out_value <= '0;
        end else begin
            state <= state_nxt;
            if (state == IDLE && in_valid) begin
                dim_m1 <= dim_of(matrix_size);
                shft   <= shift_of(matrix_size);
            end
            // Arrival order A, B, C lands in idx_q[0..2]
            if (in_valid2 && (state == IDLE || state == QUERY)) begin
                idx_q <= {matrix_idx, idx_q[2:1]};
            end
            if (last0) begin
                cnt   <= '0;
                row_i <= '0;
                drain <= 1'b1;
            end else if (v0 && cnt == cnt_lim) begin
                cnt   <= '0;
                row_i <= row_i + 4'd1;
            end else if (v0) begin
                cnt <= cnt + 5'd1;
            end
            if (l2) begin
                drain <= 1'b0;
            end
            // Delayed copies keep tags aligned with the data
            {v1, c1, l1} <= {v0, cnt, last0};
            {v2, c2, l2} <= {v1, c1, l1};
            if (state == QUERY) begin
                wr_ptr <= '0;
            end else if (t_we) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            out_valid <= (state == DONE);
            out_value <= (state == DONE) ? {{(OUT_W - ACC_W){mac.acc[ACC_W-1]}}, mac.acc} : '0;
        end
    end

endmodule

// ==== design/dot_mac.sv ====
module dot_mac (
    input  logic          clk,
    input  logic          rst_n,
    mac_cmd_if.slave      mac,
    input  mmt_pkg::row_t w_row,
    input  mmt_pkg::tmp_t t_elem
);
    import mmt_pkg::*;

    row_t               op_a;
    row_t               op_b;
    tmp_t [MAX_DIM-1:0] tbuf;
    tmp_t               lane_a;
    acc_t               sum;
    acc_t               acc_q;

    // ==================================================================
    // Operand registers
    // ==================================================================
    always_ff @(posedge clk) begin
        if (mac.load_a) begin
            op_a <= w_row;
        end
        if (mac.load_b) begin
            op_b <= w_row;
        end
        // Newest element enters lane 0
        if (mac.shift_t) begin
            tbuf <= {tbuf[MAX_DIM-2:0], t_elem};
        end
    end

    // ==================================================================
    // Sixteen lane products and adder
    // ==================================================================
    always_comb begin
        sum = '0;
        for (int l = 0; l < MAX_DIM; l++) begin
            lane_a = mac.trace_sel ? tbuf[l] : tmp_t'(op_a[l]);
            // Padded lanes of op_b are zero
            sum = sum + acc_t'(lane_a) * acc_t'(op_b[l]);
        end
        mac.dot = mac.acc_en ? sum + acc_q : sum;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc_q <= '0;
        end else if (mac.acc_clear) begin
            acc_q <= '0;
        end else if (mac.acc_en) begin
            acc_q <= mac.dot;
        end
    end

    assign mac.acc = acc_q;

endmodule

// ==== design/mmt_top.sv ====
module mmt_top #(
    parameter int NUM_MATS = 32
) (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             in_valid,
    input  logic                             in_valid2,
    input  mmt_pkg::elem_t                   matrix,
    input  logic [1:0]                       matrix_size,
    input  logic [mmt_pkg::IDX_W-1:0]        matrix_idx,
    output logic                             out_valid,
    output logic signed [mmt_pkg::OUT_W-1:0] out_value
);
    import mmt_pkg::*;

    logic                         t_we;
    logic [$clog2(TMP_DEPTH)-1:0] t_addr;
    tmp_t                         t_wdata;
    tmp_t                         t_rdata;

    mem_rd_if #(.word_t(row_t), .DEPTH(NUM_MATS * MAX_DIM)) w_rd ();
    mac_cmd_if mac ();

    matrix_store #(.NUM_MATS(NUM_MATS)) u_store (
        .clk(clk), .rst_n(rst_n), .in_valid(in_valid), .matrix(matrix),
        .matrix_size(matrix_size), .rd(w_rd.slave)
    );

    mmt_ctrl #(.NUM_MATS(NUM_MATS)) u_ctrl (
        .clk(clk), .rst_n(rst_n), .in_valid(in_valid), .in_valid2(in_valid2),
        .matrix_size(matrix_size), .matrix_idx(matrix_idx),
        .rd(w_rd.master), .mac(mac.master),
        .t_we(t_we), .t_addr(t_addr), .t_wdata(t_wdata),
        .out_valid(out_valid), .out_value(out_value)
    );

    dot_mac u_mac (
        .clk(clk), .rst_n(rst_n), .mac(mac.slave), .w_row(w_rd.rdata), .t_elem(t_rdata)
    );

    // Temporary T matrix, one element per entry
    row_sram #(.word_t(tmp_t), .DEPTH(TMP_DEPTH)) u_tmem (
        .clk(clk), .we(t_we), .addr(t_addr), .wdata(t_wdata), .rdata(t_rdata)
    );

endmodule

// ==== testbench/mmt_asserts.sv ====
module mmt_asserts (
    input logic                             clk,
    input logic                             rst_n,
    input logic                             in_valid,
    input logic                             out_valid,
    input logic signed [mmt_pkg::OUT_W-1:0] out_value
);

    // Result is a single-cycle pulse
    a_single_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |=> !out_valid)
        else $error("out_valid high on two cycles in a row");

    a_value_idle: assert property (@(posedge clk) disable iff (!rst_n)
        !out_valid |-> (out_value == '0))
        else $error("out_value nonzero while out_valid is low");

    // No result during a load
    a_quiet_load: assert property (@(posedge clk) disable iff (!rst_n)
        in_valid |-> !out_valid)
        else $error("out_valid high during a load");

endmodule

bind mmt_top mmt_asserts u_asserts (
    .clk(clk), .rst_n(rst_n), .in_valid(in_valid),
    .out_valid(out_valid), .out_value(out_value)
);

// ==== testbench/mmt_tb.sv ====
module mmt_tb;
    import mmt_pkg::*;

    localparam int NUM_MATS  = 32;
    // Loads at sizes 2, 4, 16 and 8, then at most ten queries of 600 cycles
    localparam int LOAD_CYC  = NUM_MATS * (4 + 16 + 256 + 64);
    localparam int QUERY_CYC = 10 * 600;
    localparam int WATCHDOG  = 2 * (10 + LOAD_CYC + QUERY_CYC + 200) * 10;

    logic                    clk = 1'b0;
    logic                    rst_n;
    logic                    in_valid;
    logic                    in_valid2;
    elem_t                   matrix;
    logic [1:0]              matrix_size;
    logic [IDX_W-1:0]        matrix_idx;
    logic                    out_valid;
    logic signed [OUT_W-1:0] out_value;
    elem_t                   mats [NUM_MATS][MAX_DIM][MAX_DIM];
    logic [31:0]             lfsr = 32'hbeb5_a7e6;

    always #5 clk = ~clk;

    mmt_top #(.NUM_MATS(NUM_MATS)) uut (
        .clk(clk), .rst_n(rst_n), .in_valid(in_valid), .in_valid2(in_valid2),
        .matrix(matrix), .matrix_size(matrix_size), .matrix_idx(matrix_idx),
        .out_valid(out_valid), .out_value(out_value)
    );

    // ==================================================================
    // Stimulus sources and reference model
    // ==================================================================
    // Taps 32, 22, 2, 1
    function automatic logic rand_bit();
        logic fb;
        fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function automatic elem_t rand_byte();
        elem_t b;
        for (int k = 0; k < ELEM_W; k++) begin
            b[k] = rand_bit();
        end
        return b;
    endfunction

    // Sum over i, j of (A * B^T)[i][j] * C[i][j]
    function automatic longint ref_trace(input int a, input int b, input int c, input int d);
        longint t;
        longint total;
        total = 0;
        for (int i = 0; i < d; i++) begin
            for (int j = 0; j < d; j++) begin
                t = 0;
                for (int k = 0; k < d; k++) begin
                    t += longint'(mats[a][i][k]) * longint'(mats[b][j][k]);
                end
                total += t * longint'(mats[c][i][j]);
            end
        end
        return total;
    endfunction

    task automatic check(input string name, input longint expected, input longint actual);
        if (expected !== actual) begin
            $display("Error: %s expected %h, got %h", name, expected, actual);
            $display("Simulation failed");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    // Mode 0 small pattern with identity at 0, 1 random bytes, 2 extremes
    task automatic fill_set(input int mode);
        for (int m = 0; m < NUM_MATS; m++) begin
            for (int i = 0; i < MAX_DIM; i++) begin
                for (int j = 0; j < MAX_DIM; j++) begin
                    case (mode)
                        0: mats[m][i][j] = (m == 0) ? elem_t'(i == j) : elem_t'(m - 2 * i + 3 * j - 8);
                        1: mats[m][i][j] = rand_byte();
                        default: begin
                            if (m == 0 || (m > 1 && rand_bit())) begin
                                mats[m][i][j] = elem_t'(-128);
                            end else begin
                                mats[m][i][j] = elem_t'(127);
                            end
                        end
                    endcase
                end
            end
        end
    endtask

    task automatic load_set(input logic [1:0] code);
        int d;
        d = 2 << code;
        for (int m = 0; m < NUM_MATS; m++) begin
            for (int i = 0; i < d; i++) begin
                for (int j = 0; j < d; j++) begin
                    @(posedge clk);
                    in_valid    <= 1'b1;
                    matrix_size <= code;
                    matrix      <= mats[m][i][j];
                end
            end
        end
        @(posedge clk);
        in_valid <= 1'b0;
        matrix   <= '0;
        repeat (3) @(posedge clk);
    endtask

    task automatic run_query(input int a, input int b, input int c, input longint expected);
        int idx [3];
        int wait_cyc;
        idx = '{a, b, c};
        for (int k = 0; k < 3; k++) begin
            @(posedge clk);
            in_valid2  <= 1'b1;
            matrix_idx <= IDX_W'(idx[k]);
        end
        @(posedge clk);
        in_valid2 <= 1'b0;
        wait_cyc = 0;
        @(negedge clk);
        while (!out_valid) begin
            if (wait_cyc == 2000) begin
                $display("Simulation failed");
                $fatal(1, "No out_valid within 2000 cycles for query %0d %0d %0d", a, b, c);
            end
            wait_cyc++;
            @(negedge clk);
        end
        check("out_value", expected, longint'(out_value));
        // One pulse only
        @(negedge clk);
        check("out_valid", 0, longint'(out_valid));
    endtask

    // ==================================================================
    // Directed tests
    // ==================================================================
    task automatic test_reset();
        repeat (5) begin
            @(negedge clk);
            check("out_valid", 0, longint'(out_valid));
            check("out_value", 0, longint'(out_value));
        end
    endtask

    task automatic test_size2();
        fill_set(0);
        load_set(2'd0);
        run_query(0, 0, 0, 2);
        run_query(3, 5, 7, ref_trace(3, 5, 7, 2));
    endtask

    task automatic test_size4_random();
        fill_set(1);
        load_set(2'd1);
        run_query(1, 2, 3, ref_trace(1, 2, 3, 4));
        run_query(5, 5, 5, ref_trace(5, 5, 5, 4));
        run_query(31, 0, 31, ref_trace(31, 0, 31, 4));
    endtask

    // Matrix 0 all -128, matrix 1 all 127, so query 0 1 1 is large and negative
    task automatic test_size16_extremes();
        fill_set(2);
        load_set(2'd3);
        run_query(0, 1, 1, ref_trace(0, 1, 1, 16));
        run_query(2, 3, 4, ref_trace(2, 3, 4, 16));
    endtask

    task automatic test_reload8();
        fill_set(1);
        load_set(2'd2);
        run_query(0, 1, 2, ref_trace(0, 1, 2, 8));
        run_query(30, 31, 6, ref_trace(30, 31, 6, 8));
    endtask

    initial begin
        rst_n       = 1'b0;
        in_valid    = 1'b0;
        in_valid2   = 1'b0;
        matrix      = '0;
        matrix_size = '0;
        matrix_idx  = '0;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        test_reset();
        test_size2();
        test_size4_random();
        test_size16_extremes();
        test_reload8();
        $display("Simulation completed successfully");
        $finish;
    end

    initial begin
        #(WATCHDOG);
        $display("Simulation failed");
        $fatal(1, "Watchdog expired before the tests finished");
    end

endmodule

// ==== compile.f ====
design/mmt_pkg.sv
design/mmt_ifs.sv
design/row_sram.sv
design/matrix_store.sv
design/mmt_ctrl.sv
design/dot_mac.sv
design/mmt_top.sv
testbench/mmt_asserts.sv
testbench/mmt_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f compile.f --top-module mmt_tb -o mmt_sim
./obj_dir/mmt_sim
